// File: dct_axi_top.f
+incdir+include
hw/dct_axi_pkg.sv
hw/dct_axi_slave.sv
hw/dct_block_engine.sv
hw/dct_result_ram.sv
hw/dct_axi_top.sv
test/dct_axi_chk.sv
test/dct_axi_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the dct accelerator testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/dct_axi_sim

verilator --binary --timing --assert -f dct_axi_top.f \
	--top-module dct_axi_tb --Mdir obj_dir -o dct_axi_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

# keep running past assertion errors so the testbench reports the result
"$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
exit 1

// File: test/dct_axi_tb.sv
`timescale 1ns/1ps

`include "dct_axi_consts.svh"

module dct_axi_tb
	import dct_axi_pkg::*;
();

	// 1 + 8 + 4 + 1 + 2 blocks over all tests
	localparam int N_BLOCKS  = 16;
	localparam int WD_CYCLES = N_BLOCKS * 200 + 2000;

	logic                     aclk;
	logic                     aresetn;
	logic [`DCT_AXI_AW-1:0]   awaddr;
	logic                     awvalid;
	logic                     awready;
	logic [`DCT_AXI_DW-1:0]   wdata;
	logic [`DCT_AXI_DW/8-1:0] wstrb;
	logic                     wvalid;
	logic                     wready;
	logic [1:0]               bresp;
	logic                     bvalid;
	logic                     bready;
	logic [`DCT_AXI_AW-1:0]   araddr;
	logic                     arvalid;
	logic                     arready;
	logic [`DCT_AXI_DW-1:0]   rdata;
	logic [1:0]               rresp;
	logic                     rvalid;
	logic                     rready;

	// expected result bytes in ram order, and register-0 words still to compare
	logic [7:0]  exp_q [$];
	logic [31:0] rd_q [$];
	int checks;
	int errors;
	int err_mark;
	// longest random hold of bready and rready, 0 means accept at once
	int stall_max;

	dct_axi_top DUT (.*);

	initial
	begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// byte n of blk is sample n, byte k of the result is coefficient k
	function automatic logic [63:0] dct_ref(input logic [63:0] blk);
		logic [63:0] res;
		int acc;
		int c;
		res = '0;
		for (int k = 0; k < `DCT_N; k++)
		begin
			acc = 0;
			for (int n = 0; n < `DCT_N; n++)
			begin
				c = int'(coeff_table[k][n]);
				acc = acc + int'(blk[8*n +: 8]) * c;
			end
			// floor division by 1024, then clip to signed 8 bit
			acc = acc >>> `DCT_COEFF_SHIFT;
			if (acc > 127)
				acc = 127;
			if (acc < -128)
				acc = -128;
			res[8*k +: 8] = acc[7:0];
		end
		return res;
	endfunction

	function automatic logic [63:0] rand_block();
		return {$urandom, $urandom};
	endfunction

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// bus driver
	//////////////////////////////

	task automatic idle(input int n);
		repeat (n) @(posedge aclk);
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		int n;
		n = int'($urandom_range(stall_max, 0));
		awaddr  <= addr;
		wdata   <= data;
		// strobes carry no meaning for this slave
		wstrb   <= 4'($urandom);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(posedge aclk);
		while (!awready)
			@(posedge aclk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(posedge aclk);
		while (!bvalid)
			@(posedge aclk);
		// hold the response back for n cycles
		repeat (n)
		begin
			@(posedge aclk);
			if (!bvalid)
			begin
				errors++;
				$display("write response was withdrawn before bready");
			end
		end
		bready <= 1'b1;
		@(posedge aclk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
		int n;
		n = int'($urandom_range(stall_max, 0));
		araddr  <= addr;
		arvalid <= 1'b1;
		@(posedge aclk);
		while (!arready)
			@(posedge aclk);
		arvalid <= 1'b0;
		@(posedge aclk);
		while (!rvalid)
			@(posedge aclk);
		repeat (n)
		begin
			@(posedge aclk);
			if (!rvalid)
			begin
				errors++;
				$display("read response was withdrawn before rready");
			end
		end
		rready <= 1'b1;
		@(posedge aclk);
		// data is taken in the handshake cycle
		data = rdata;
		rready <= 1'b0;
		// data words go to the compare process
		if (addr[3:2] == `DCT_REG_DATA)
			rd_q.push_back(data);
	endtask

	// four pair writes to register 0, optionally mixed with writes to 0x8 and 0xc
	task automatic send_block(input logic [63:0] blk, input bit mix);
		logic [63:0] res;
		for (int p = 0; p < `DCT_N / 2; p++)
		begin
			axi_write(32'h0, {16'($urandom), blk[16*p +: 16]});
			if (mix && p < 2)
				axi_write((p == 0) ? 32'h8 : 32'hc, $urandom);
		end
		res = dct_ref(blk);
		for (int k = 0; k < `DCT_N; k++)
			exp_q.push_back(res[8*k +: 8]);
		// last pair lands 9 cycles after the last strobe
		idle(12);
	endtask

	task automatic read_words(input int n);
		logic [31:0] d;
		for (int i = 0; i < n; i++)
			axi_read(32'h0, d);
	endtask

	task automatic end_test(input string name);
		// let the compare process drain
		idle(2);
		$display("test %s: %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	//////////////////////////////
	// compare and watchdog
	//////////////////////////////

	// negedge keeps clear of the posedge pushes
	initial
	begin : compare
		logic [31:0] word;
		logic [31:0] exp;
		forever
		begin
			@(negedge aclk);
			while (rd_q.size() != 0)
			begin
				word = rd_q.pop_front();
				if (exp_q.size() < 4)
				begin
					errors++;
					$display("register 0 returned a word while no result was expected");
				end
				else
				begin
					exp = '0;
					for (int b = 0; b < 4; b++)
						exp[8*b +: 8] = exp_q.pop_front();
					check_val("register 0", word, exp);
				end
			end
		end
	end

	initial
	begin : watchdog
		repeat (WD_CYCLES) @(posedge aclk);
		$display("run timed out after %0d cycles, the DUT stopped answering the bus", WD_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin : main
		logic [31:0] d;
		int polls;
		d = $urandom(32'h3b9f);
		checks    = 0;
		errors    = 0;
		err_mark  = 0;
		stall_max = 0;
		aresetn <= 1'b0;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		repeat (10) @(posedge aclk);
		aresetn <= 1'b1;
		@(posedge aclk);

		check_val("bvalid after reset", 32'(bvalid), 32'h0);
		check_val("rvalid after reset", 32'(rvalid), 32'h0);
		axi_read(32'h4, d);
		check_val("register 1", d, 32'h0);
		end_test("reset state");

		// bright samples drive the dc term into saturation
		send_block(64'h80ff_4020_0010_ff00, 1'b0);
		polls = 0;
		d     = '0;
		while (d[0] !== 1'b1 && polls < 50)
		begin
			axi_read(32'h4, d);
			polls++;
		end
		if (d[0] !== 1'b1)
		begin
			errors++;
			$display("status flag never set after the first block");
		end
		read_words(2);
		end_test("one block");

		// full ram, both pointers come round to 8 again
		for (int i = 0; i < 8; i++)
			send_block(rand_block(), 1'b0);
		read_words(16);
		end_test("random blocks");
		for (int i = 0; i < 4; i++)
			send_block(rand_block(), 1'b0);
		read_words(8);
		end_test("after wrap");

		send_block(rand_block(), 1'b1);
		read_words(2);
		axi_read(32'h8, d);
		check_val("register 2", d, 32'h0);
		axi_read(32'hc, d);
		check_val("register 3", d, 32'h0);
		axi_read(32'h4, d);
		check_val("register 1", d, 32'h1);
		end_test("ignored registers");

		stall_max = 6;
		for (int i = 0; i < 2; i++)
			send_block(rand_block(), 1'b0);
		read_words(4);
		stall_max = 0;
		end_test("back-pressure");

		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%0d expected results were never read back", exp_q.size());
		end
		errors = errors + DUT.u_chk.fail_cnt;
		$display("checks %0d, assertion failures %0d, errors %0d",
			checks, DUT.u_chk.fail_cnt, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: test/dct_axi_chk.sv
`timescale 1ns/1ps

module dct_axi_chk (
	input logic       aclk,
	input logic       aresetn,
	input logic       awready,
	input logic       wready,
	input logic [1:0] bresp,
	input logic       bvalid,
	input logic       bready,
	input logic [1:0] rresp,
	input logic       rvalid,
	input logic       rready,
	input logic       sample_stb,
	input logic       rd_pop
);

	// failed assertions, read by the testbench at the end
	int fail_cnt = 0;

	//////////////////////////////
	// response channels
	//////////////////////////////

	// a response waits for its ready
	a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		bvalid && !bready |=> bvalid)
	else
	begin
		$error("bvalid dropped before bready");
		fail_cnt++;
	end

	a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		rvalid && !rready |=> rvalid)
	else
	begin
		$error("rvalid dropped before rready");
		fail_cnt++;
	end

	// aw and w are always taken together
	// and never while a write response waits
	a_ready_pair: assert property (@(posedge aclk) disable iff (!aresetn)
		awready == wready && !(awready && bvalid))
	else
	begin
		$error("awready and wready differ or rise during a pending response");
		fail_cnt++;
	end

	a_okay: assert property (@(posedge aclk) bresp == 2'b00 && rresp == 2'b00)
	else
	begin
		$error("response other than okay");
		fail_cnt++;
	end

	// internal strobes come in the cycle their response valid rises
	a_strobes: assert property (@(posedge aclk) disable iff (!aresetn)
		(!sample_stb || $rose(bvalid)) && (!rd_pop || $rose(rvalid)))
	else
	begin
		$error("sample strobe or pop out of step with its response");
		fail_cnt++;
	end

endmodule

bind dct_axi_top dct_axi_chk u_chk (
	.aclk       (aclk),
	.aresetn    (aresetn),
	.awready    (awready),
	.wready     (wready),
	.bresp      (bresp),
	.bvalid     (bvalid),
	.bready     (bready),
	.rresp      (rresp),
	.rvalid     (rvalid),
	.rready     (rready),
	.sample_stb (samples.stb),
	.rd_pop     (rd_pop)
);

// File: hw/dct_axi_top.sv
`timescale 1ns/1ps

`include "dct_axi_consts.svh"

module dct_axi_top
	import dct_axi_pkg::*;
(
	input  logic                    aclk,
	input  logic                    aresetn,
	input  logic [`DCT_AXI_AW-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`DCT_AXI_DW-1:0]   wdata,
	input  logic [`DCT_AXI_DW/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [`DCT_AXI_AW-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`DCT_AXI_DW-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready
);

	// slave to engine, one pulse per register-0 write
	sample_pair_t samples;
	// engine to ram, one pulse per coefficient pair
	result_pair_t results;
	// ram window and flag back to the slave
	logic [`DCT_AXI_DW-1:0] rd_bytes;
	logic                  out_valid;
	logic                  rd_pop;

	dct_axi_slave u_slave (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.rd_bytes  (rd_bytes),
		.out_valid (out_valid),
		.samples   (samples),
		.rd_pop    (rd_pop)
	);

	dct_block_engine u_engine (
		.aclk    (aclk),
		.aresetn (aresetn),
		.samples (samples),
		.results (results)
	);

	dct_result_ram u_ram (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.results   (results),
		.rd_pop    (rd_pop),
		.rd_bytes  (rd_bytes),
		.out_valid (out_valid)
	);

endmodule

// File: hw/dct_result_ram.sv
`timescale 1ns/1ps

`include "dct_axi_consts.svh"

module dct_result_ram
	import dct_axi_pkg::*;
(
	input  logic                  aclk,
	input  logic                  aresetn,
	input  result_pair_t          results,
	input  logic                  rd_pop,
	output logic [`DCT_AXI_DW-1:0] rd_bytes,
	output logic                  out_valid
);

	localparam int AW    = `DCT_RAM_AW;
	localparam int DEPTH = 2 ** AW;
	localparam int BPW   = `DCT_AXI_DW / `DCT_RESULT_W;

	logic [`DCT_RESULT_W-1:0] mem [DEPTH];

	// both pointers wrap at the ram size by width
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;

	//////////////////////////////
	// write side and pointers
	//////////////////////////////

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			wptr      <= '0;
			rptr      <= '0;
			out_valid <= 1'b0;
			for (int a = 0; a < DEPTH; a++)
			begin
				mem[a] <= '0;
			end
		end
		else
		begin
			// one result pair per strobe, even entry first
			if (results.stb)
			begin
				mem[wptr]         <= results.r0;
				mem[wptr + AW'(1)] <= results.r1;
				wptr              <= wptr + AW'(2);
				// sticky until reset
				out_valid         <= 1'b1;
			end
			// host consumed one word
			if (rd_pop)
			begin
				rptr <= rptr + AW'(BPW);
			end
		end
	end

	//////////////////////////////
	// read window
	//////////////////////////////

	// four entries from the read pointer, lowest address in the low byte
	always_comb
	begin
		for (int b = 0; b < BPW; b++)
		begin
			rd_bytes[b*`DCT_RESULT_W +: `DCT_RESULT_W] = mem[rptr + AW'(b)];
		end
	end

endmodule

// File: hw/dct_block_engine.sv
`timescale 1ns/1ps

`include "dct_axi_consts.svh"

module dct_block_engine
	import dct_axi_pkg::*;
(
	input  logic         aclk,
	input  logic         aresetn,
	input  sample_pair_t samples,
	output result_pair_t results
);

	// 9-bit unsigned-as-signed sample times 12-bit coefficient
	localparam int PROD_W = `DCT_SAMPLE_W + 1 + `DCT_COEFF_W;
	// headroom for the sum of N products
	localparam int ACC_W  = PROD_W + $clog2(`DCT_N);
	localparam int SCL_W  = ACC_W - `DCT_COEFF_SHIFT;
	localparam int KW     = $clog2(`DCT_N);
	localparam int PW     = KW - 1;

	localparam logic signed [SCL_W-1:0] RES_MAX = (1 <<< (`DCT_RESULT_W - 1)) - 1;
	localparam logic signed [SCL_W-1:0] RES_MIN = -(1 <<< (`DCT_RESULT_W - 1));

	// collect buffer fills while the work registers are transformed
	logic [`DCT_SAMPLE_W-1:0] coll [`DCT_N];
	logic [`DCT_SAMPLE_W-1:0] work [`DCT_N];
	logic [PW-1:0]            pair_cnt;
	logic                     blk_last;

	// output sequencing
	logic                     busy;
	logic [KW-1:0]            k;

	logic signed [ACC_W-1:0]         acc;
	logic signed [SCL_W-1:0]         scaled;
	logic signed [`DCT_RESULT_W-1:0] coef_out;
	logic signed [`DCT_RESULT_W-1:0] held;
	logic signed [`DCT_RESULT_W-1:0] res_lo;
	logic signed [`DCT_RESULT_W-1:0] res_hi;
	logic                            res_stb;

	//////////////////////////////
	// sample collection
	//////////////////////////////

	// fourth pair closes the block
	assign blk_last = samples.stb && (pair_cnt == PW'(`DCT_N / 2 - 1));

	always_ff @(posedge aclk)
	begin
		if (samples.stb)
		begin
			coll[{pair_cnt, 1'b0}] <= samples.s0;
			coll[{pair_cnt, 1'b1}] <= samples.s1;
		end
		// block moves over together with its last pair
		if (blk_last)
		begin
			for (int n = 0; n < `DCT_N - 2; n++)
			begin
				work[n] <= coll[n];
			end
			work[`DCT_N-2] <= samples.s0;
			work[`DCT_N-1] <= samples.s1;
		end
	end

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			pair_cnt <= '0;
			busy     <= 1'b0;
			k        <= '0;
			res_stb  <= 1'b0;
		end
		else
		begin
			res_stb <= 1'b0;
			if (samples.stb)
			begin
				pair_cnt <= pair_cnt + PW'(1);
			end
			if (blk_last)
			begin
				busy <= 1'b1;
				k    <= '0;
			end
			else if (busy)
			begin
				k <= k + KW'(1);
				if (k == KW'(`DCT_N - 1))
				begin
					busy <= 1'b0;
				end
			end
			// odd k completes a pair
			if (busy && k[0])
			begin
				res_stb <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// one coefficient per cycle
	//////////////////////////////

	always_comb
	begin
		acc = '0;
		// dot product of the block with row k
		for (int n = 0; n < `DCT_N; n++)
		begin
			acc = acc + ACC_W'($signed({1'b0, work[n]})) * ACC_W'(coeff_table[k][n]);
		end
		// drop the fraction bits, arithmetic shift keeps the sign
		scaled = SCL_W'(acc >>> `DCT_COEFF_SHIFT);
		// clip to signed 8 bit
		if (scaled > RES_MAX)
		begin
			coef_out = RES_MAX[`DCT_RESULT_W-1:0];
		end
		else if (scaled < RES_MIN)
		begin
			coef_out = RES_MIN[`DCT_RESULT_W-1:0];
		end
		else
		begin
			coef_out = scaled[`DCT_RESULT_W-1:0];
		end
	end

	// even k waits in held, odd k releases the pair
	always_ff @(posedge aclk)
	begin
		if (busy)
		begin
			if (!k[0])
			begin
				held <= coef_out;
			end
			else
			begin
				res_lo <= held;
				res_hi <= coef_out;
			end
		end
	end

	assign results = '{r0: res_lo, r1: res_hi, stb: res_stb};

endmodule

// File: hw/dct_axi_slave.sv
`timescale 1ns/1ps

`include "dct_axi_consts.svh"

module dct_axi_slave
	import dct_axi_pkg::*;
(
	input  logic                    aclk,
	input  logic                    aresetn,
	// write address and data
	input  logic [`DCT_AXI_AW-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`DCT_AXI_DW-1:0]   wdata,
	input  logic [`DCT_AXI_DW/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	// write response
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	// read address and data
	input  logic [`DCT_AXI_AW-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`DCT_AXI_DW-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	// result ram side
	input  logic [`DCT_AXI_DW-1:0]   rd_bytes,
	input  logic                    out_valid,
	output sample_pair_t            samples,
	output logic                    rd_pop
);

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// shared ready for aw and w, both channels accepted together
	logic       wr_rdy;
	logic       wr_start;
	logic       wr_go;
	logic [1:0] aw_idx;

	logic       rd_start;
	logic       rd_go;
	logic [1:0] ar_idx;

	// registered sample pair towards the engine
	logic [`DCT_SAMPLE_W-1:0] smp_first;
	logic [`DCT_SAMPLE_W-1:0] smp_second;
	logic                     smp_stb;

	rd_word_u rd_word;

	//////////////////////////////
	// write channel
	//////////////////////////////

	// wstrb is not decoded, a write always carries a full sample pair

	// only one write in flight, nothing new while the response waits
	assign wr_start = !wr_rdy && awvalid && wvalid && !bvalid;
	assign wr_go    = wr_rdy && awvalid && wvalid;

	assign awready = wr_rdy;
	assign wready  = wr_rdy;
	assign bresp   = RESP_OKAY;

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			wr_rdy  <= 1'b0;
			bvalid  <= 1'b0;
			smp_stb <= 1'b0;
		end
		else
		begin
			// ready is a single-cycle pulse
			wr_rdy  <= wr_start;
			smp_stb <= 1'b0;
			if (wr_go)
			begin
				bvalid  <= 1'b1;
				// only the data register feeds the engine
				smp_stb <= (aw_idx == `DCT_REG_DATA);
			end
			else if (bvalid && bready)
			begin
				bvalid <= 1'b0;
			end
		end
	end

	// address index and write data capture
	always_ff @(posedge aclk)
	begin
		if (wr_start)
		begin
			aw_idx <= awaddr[3:2];
		end
		if (wr_go)
		begin
			smp_first  <= wdata[`DCT_SAMPLE_W-1:0];
			smp_second <= wdata[2*`DCT_SAMPLE_W-1:`DCT_SAMPLE_W];
		end
	end

	assign samples = '{s0: smp_first, s1: smp_second, stb: smp_stb};

	//////////////////////////////
	// read channel
	//////////////////////////////

	assign rd_start = !arready && arvalid && !rvalid;
	assign rd_go    = arready && arvalid;
	assign rresp    = RESP_OKAY;

	// register decode of the latched read index
	always_comb
	begin
		rd_word = '0;
		case (ar_idx)
			`DCT_REG_DATA:
			begin
				rd_word.bytes = rd_bytes;
			end
			`DCT_REG_STATUS:
			begin
				rd_word.status.valid = out_valid;
			end
			default:
			begin
				rd_word = '0;
			end
		endcase
	end

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rd_pop  <= 1'b0;
		end
		else
		begin
			arready <= rd_start;
			rd_pop  <= 1'b0;
			if (rd_go)
			begin
				rvalid <= 1'b1;
				// pointer moves after rdata has sampled the old entries
				rd_pop <= (ar_idx == `DCT_REG_DATA);
			end
			else if (rvalid && rready)
			begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk)
	begin
		if (rd_start)
		begin
			ar_idx <= araddr[3:2];
		end
		// rdata holds until the next accepted read
		if (rd_go)
		begin
			rdata <= rd_word;
		end
	end

endmodule

// File: hw/dct_axi_pkg.sv
`include "dct_axi_consts.svh"

package dct_axi_pkg;

	// one register-0 write, two samples at once
	// s0 comes from wdata[7:0], s1 from wdata[15:8]
	typedef struct packed {
		logic [`DCT_SAMPLE_W-1:0] s0;
		logic [`DCT_SAMPLE_W-1:0] s1;
		logic                     stb;
	} sample_pair_t;

	// two neighbouring coefficients, r0 is the even k
	typedef struct packed {
		logic signed [`DCT_RESULT_W-1:0] r0;
		logic signed [`DCT_RESULT_W-1:0] r1;
		logic                            stb;
	} result_pair_t;

	// read data word, decoded by register index
	// bytes[0] holds the result at the read pointer
	typedef union packed {
		logic [3:0][`DCT_RESULT_W-1:0] bytes;
		struct packed {
			logic [`DCT_AXI_DW-2:0] zero;
			logic                   valid;
		} status;
	} rd_word_u;

	//////////////////////////////
	// dct-ii basis, scaled by 1024
	//////////////////////////////

	// row k, column n, row 0 uses 1/sqrt(8), others 1/2
	localparam logic signed [`DCT_COEFF_W-1:0] coeff_table [`DCT_N][`DCT_N] = '{
		'{ 362,  362,  362,  362,  362,  362,  362,  362},
		'{ 502,  426,  284,  100, -100, -284, -426, -502},
		'{ 473,  196, -196, -473, -473, -196,  196,  473},
		'{ 426, -100, -502, -284,  284,  502,  100, -426},
		'{ 362, -362, -362,  362,  362, -362, -362,  362},
		'{ 284, -502,  100,  426, -426, -100,  502, -284},
		'{ 196, -473,  473, -196, -196,  473, -473,  196},
		'{ 100, -284,  426, -502,  502, -426,  284, -100}
	};

endpackage

// File: include/dct_axi_consts.svh
`ifndef DCT_AXI_CONSTS_SVH
`define DCT_AXI_CONSTS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

// unsigned input sample
`define DCT_SAMPLE_W 8
// signed basis coefficient, Q1.10
`define DCT_COEFF_W 12
`define DCT_COEFF_SHIFT 10
// saturated signed output
`define DCT_RESULT_W 8
// samples per transform block
`define DCT_N 8

//////////////////////////////
// memory map and bus
//////////////////////////////

// 64 results in the output ram
`define DCT_RAM_AW 6
// register index, taken from address bits [3:2]
`define DCT_REG_DATA 2'd0
`define DCT_REG_STATUS 2'd1
`define DCT_AXI_DW 32
`define DCT_AXI_AW 32

`endif
